//--- filelist.f
hw/pipe_pkg.sv
hw/insn_pkg.sv
hw/stage_reg.sv
hw/fe_predecode.sv
hw/branch_recovery_fsm.sv
hw/fe_flush_ctrl.sv
hw/frontend_top.sv
tests/frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the front-end testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module frontend_tb -f filelist.f -o Vfrontend_tb

./obj_dir/Vfrontend_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

//--- tests/frontend_tb.sv
//====================
// Front-end testbench
// Random fetch stream checked cycle by cycle against a model of the front end
//====================

`timescale 1ns/1ps

module frontend_tb;

	localparam int RUN_CYCLES     = 1500;
	// Run length plus a third for reset and drain
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;
	localparam int RCV_CYCLES     = 4;
	localparam logic [31:0] START_PC = 32'h0000_1000;

	// Clock starts low before any process runs, so time zero has no edge
	logic clk = 1'b0;
	logic rst, ihit, hold_front, hold_back, branchmiss;
	logic [31:0] fetch_pc;
	insn_pkg::insn_t fetch_word;
	logic que_valid, que_copy, recovering;
	logic [31:0] que_pc;
	insn_pkg::opcode_t que_opcode;
	logic [5:0] que_tag;

	//====================
	// Cycle model state
	//====================

	logic m_fet_v, m_mux_v, m_dec_v, m_ren_v, m_que_v;
	logic [31:0] m_fet_pc, m_mux_pc, m_dec_pc, m_ren_pc, m_que_pc;
	logic [31:0] m_fet_word, m_mux_word;
	logic [5:0] m_dec_op, m_ren_op, m_que_op, m_ren_tag, m_que_tag, m_tag_cnt;
	logic m_s_mux, m_s_dec, m_s_ren, m_s_que, m_s_quem, m_bsr_d;
	int m_ucnt, m_bstate;

	int seed = 83;
	int errors, cycle, wd_cycles, entries, copies, rcv_run, recoveries;
	logic edge_hold_back;
	logic [31:0] last_pc, snap_pc;
	logic snap_valid, snap_copy;
	logic [5:0] snap_op, snap_tag;

	frontend_top DUT (
		.clk(clk), .rst(rst), .ihit(ihit), .fetch_pc(fetch_pc), .fetch_word(fetch_word),
		.hold_front(hold_front), .hold_back(hold_back), .branchmiss(branchmiss),
		.que_valid(que_valid), .que_copy(que_copy), .que_pc(que_pc),
		.que_opcode(que_opcode), .que_tag(que_tag), .recovering(recovering)
	);

	always #5 clk = ~clk;

	// One model step per rising edge, from the inputs the DUT sees at that edge
	task automatic model_step();
		logic adv2, adv1, bsr, s_fet, mor, n_mux, n_dec, n_ren;
		logic mux_live, dec_live, ren_live, ucode_start, tag_alloc;
		adv2 = !hold_back;
		adv1 = adv2 && !hold_front;
		bsr = (m_fet_word[31:26] == insn_pkg::OP_BSR);
		mor = branchmiss || (m_bstate != 0);
		s_fet = !ihit && (bsr || m_bsr_d);
		// Fetch stomp is masked while micro-code runs
		n_mux = (s_fet && (m_ucnt == 0)) || bsr || mor;
		n_dec = m_s_mux || mor;
		n_ren = m_s_dec || mor;
		mux_live = m_mux_v && !m_s_mux;
		dec_live = m_dec_v && !m_s_dec;
		ren_live = m_ren_v && !m_s_ren;
		ucode_start = adv1 && mux_live && (m_mux_word[31:26] == insn_pkg::OP_UCODE);
		tag_alloc = adv1 && dec_live && !mor;
		// Payloads follow the advance enables, reset or not
		if (adv2) begin
			m_que_pc = m_ren_pc;
			m_que_op = m_ren_op;
			m_que_tag = m_ren_tag;
			m_ren_pc = m_dec_pc;
			m_ren_op = m_dec_op;
			m_ren_tag = m_tag_cnt;
		end
		if (adv1) begin
			m_dec_pc = m_mux_pc;
			m_dec_op = m_mux_word[31:26];
			m_mux_pc = m_fet_pc;
			m_mux_word = m_fet_word;
			m_fet_pc = fetch_pc;
			m_fet_word = fetch_word;
		end
		if (rst) begin
			{m_fet_v, m_mux_v, m_dec_v, m_ren_v, m_que_v} = '0;
			{m_s_mux, m_s_dec, m_s_ren, m_s_que, m_s_quem} = '1;
			m_bsr_d = 1'b0;
			m_ucnt = 0;
			m_bstate = 0;
			m_tag_cnt = '0;
		end else begin
			if (adv2) begin
				m_que_v = ren_live;
				m_ren_v = dec_live;
				m_s_que = m_s_ren;
				// Segment 2 moving alone puts a bubble into rename
				m_s_ren = adv1 ? n_ren : 1'b1;
				m_s_quem = mor;
			end
			if (adv1) begin
				m_dec_v = mux_live;
				m_mux_v = m_fet_v;
				m_fet_v = 1'b1;
				m_s_mux = n_mux;
				m_s_dec = n_dec;
				m_bsr_d = bsr;
			end
			if (tag_alloc)
				m_tag_cnt = m_tag_cnt + 6'd1;
			if (ucode_start)
				m_ucnt = pipe_pkg::UCODE_LEN;
			else if (m_ucnt != 0)
				m_ucnt = m_ucnt - 1;
			// Recovery walks four steps after a miss seen in idle
			if (m_bstate == RCV_CYCLES)
				m_bstate = 0;
			else if (m_bstate != 0)
				m_bstate = m_bstate + 1;
			else if (branchmiss)
				m_bstate = 1;
		end
	endtask

	task automatic drive_random();
		int unsigned r;
		logic [5:0] opc;
		r = $random(seed);
		ihit <= (r % 100) >= 20;
		r = $random(seed);
		hold_front <= (r % 100) < 15;
		r = $random(seed);
		hold_back <= (r % 100) < 15;
		r = $random(seed);
		branchmiss <= (r % 40) == 0;
		r = $random(seed);
		if (r % 10 == 0) begin
			opc = insn_pkg::OP_BSR;
		end else if (r % 10 == 1) begin
			opc = insn_pkg::OP_UCODE;
		end else begin
			opc = 6'($random(seed));
			if (opc == insn_pkg::OP_BSR || opc == insn_pkg::OP_UCODE)
				opc = insn_pkg::OP_ADD;
		end
		fetch_pc <= fetch_pc + 32'd4;
		fetch_word <= {opc, 26'($random(seed))};
	endtask

	task automatic check_outputs();
		logic exp_valid, exp_copy, exp_rcv;
		exp_valid = m_que_v && !m_s_que && !m_s_quem;
		exp_copy = m_que_v && !m_s_que && m_s_quem;
		exp_rcv = (m_bstate != 0);
		assert (que_valid === exp_valid && que_copy === exp_copy) else begin
			errors++;
			$display("CHECK FAILED at %0t: queue flags valid=%b copy=%b, expected %b %b",
				$time, que_valid, que_copy, exp_valid, exp_copy);
		end
		assert (recovering === exp_rcv) else begin
			errors++;
			$display("CHECK FAILED at %0t: recovering=%b, expected %b", $time, recovering, exp_rcv);
		end
		if (exp_valid || exp_copy) begin
			assert (que_pc === m_que_pc && que_opcode === m_que_op && que_tag === m_que_tag)
			else begin
				errors++;
				$display("CHECK FAILED at %0t: queue pc=%h op=%h tag=%0d, expected %h %h %0d",
					$time, que_pc, que_opcode, que_tag, m_que_pc, m_que_op, m_que_tag);
			end
		end
		// Back-pressure freezes everything the queue shows
		if (edge_hold_back) begin
			assert (que_valid === snap_valid && que_copy === snap_copy && que_pc === snap_pc
				&& que_opcode === snap_op && que_tag === snap_tag) else begin
				errors++;
				$display("CHECK FAILED at %0t: queue outputs changed under hold_back", $time);
			end
		end else if (que_valid || que_copy) begin
			entries++;
			if (que_copy)
				copies++;
			assert (que_pc > last_pc) else begin
				errors++;
				$display("CHECK FAILED at %0t: queue pc %h not after %h", $time, que_pc, last_pc);
			end
			last_pc = que_pc;
		end
		if (recovering) begin
			rcv_run++;
		end else if (rcv_run != 0) begin
			assert (rcv_run == RCV_CYCLES) else begin
				errors++;
				$display("CHECK FAILED at %0t: recovery lasted %0d cycles", $time, rcv_run);
			end
			recoveries++;
			rcv_run = 0;
		end
		snap_valid = que_valid;
		snap_copy = que_copy;
		snap_pc = que_pc;
		snap_op = que_opcode;
		snap_tag = que_tag;
	endtask

	always @(posedge clk) begin
		edge_hold_back = hold_back;
		model_step();
		if (!rst)
			drive_random();
	end

	// Outputs are settled half a period after the edge
	always @(negedge clk) begin
		check_outputs();
		cycle++;
	end

	always @(posedge clk) begin
		wd_cycles++;
		if (wd_cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		ihit = 1'b1;
		hold_front = 1'b0;
		hold_back = 1'b0;
		branchmiss = 1'b0;
		fetch_pc = START_PC;
		fetch_word = '0;
		edge_hold_back = 1'b0;
		last_pc = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		wait (cycle >= RUN_CYCLES);
		$display("Run done: %0d errors, %0d queue entries, %0d copies, %0d recoveries",
			errors, entries, copies, recoveries);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- hw/frontend_top.sv
//====================
// Instruction front end
// Fetch, mux, decode, rename and queue with flush control
//====================

`timescale 1ns/1ps

module frontend_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ihit,
	input  logic [insn_pkg::PC_W-1:0]     fetch_pc,
	input  insn_pkg::insn_t               fetch_word,
	input  logic                          hold_front,
	input  logic                          hold_back,
	input  logic                          branchmiss,
	output logic                          que_valid,
	output logic                          que_copy,
	output logic [insn_pkg::PC_W-1:0]     que_pc,
	output insn_pkg::opcode_t             que_opcode,
	output logic [insn_pkg::TAG_W-1:0]    que_tag,
	output logic                          recovering
);

	logic advance_pipeline;
	logic advance_seg2;
	logic stomp_mux;
	logic stomp_dec;
	logic stomp_ren;
	logic stomp_que;
	logic stomp_quem;
	logic do_bsr;
	logic micro_code_active;
	pipe_pkg::branch_state_t branch_state;

	insn_pkg::fetch_pkt_t fet_d;
	insn_pkg::fetch_pkt_t fet_q;
	insn_pkg::fetch_pkt_t mux_q;
	insn_pkg::dec_pkt_t   dec_d;
	insn_pkg::dec_pkt_t   dec_q;
	insn_pkg::ren_pkt_t   ren_d;
	insn_pkg::ren_pkt_t   ren_q;
	insn_pkg::ren_pkt_t   que_q;
	logic fet_v;
	logic mux_v;
	logic dec_v;
	logic ren_v;
	logic que_v;

	// Stage contents that survived their own stomp
	logic mux_live;
	logic dec_live;
	logic ren_live;

	logic [insn_pkg::TAG_W-1:0] tag_cnt;
	logic                       tag_alloc;

	//====================
	// Segment 1
	//====================

	// Fetch captures a word on every step, stomp_fet acts through stomp_mux
	always_comb begin
		fet_d.pc   = fetch_pc;
		fet_d.word = fetch_word;
	end

	stage_reg #(.payload_t(insn_pkg::fetch_pkt_t)) u_fet (
		.clk(clk), .rst(rst), .advance(advance_pipeline),
		.in_valid(1'b1), .in_data(fet_d), .out_valid(fet_v), .out_data(fet_q)
	);

	stage_reg #(.payload_t(insn_pkg::fetch_pkt_t)) u_mux (
		.clk(clk), .rst(rst), .advance(advance_pipeline),
		.in_valid(fet_v), .in_data(fet_q), .out_valid(mux_v), .out_data(mux_q)
	);

	assign mux_live = mux_v && !stomp_mux;

	always_comb begin
		dec_d.pc     = mux_q.pc;
		dec_d.opcode = insn_pkg::opcode_of(mux_q.word);
		dec_d.rd     = insn_pkg::rd_of(mux_q.word);
	end

	stage_reg #(.payload_t(insn_pkg::dec_pkt_t)) u_dec (
		.clk(clk), .rst(rst), .advance(advance_pipeline),
		.in_valid(mux_live), .in_data(dec_d), .out_valid(dec_v), .out_data(dec_q)
	);

	assign dec_live = dec_v && !stomp_dec;

	//====================
	// Segment 2
	//====================

	// A tag goes out only when decode really hands over a word that rename keeps
	// Words caught by a miss or recovery at this edge are stomped in rename
	assign tag_alloc = advance_seg2 && advance_pipeline && dec_live
		&& !branchmiss && !recovering;

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_cnt <= '0;
		end else if (tag_alloc) begin
			tag_cnt <= tag_cnt + 1'b1;
		end
	end

	always_comb begin
		ren_d.pc     = dec_q.pc;
		ren_d.opcode = dec_q.opcode;
		ren_d.rd     = dec_q.rd;
		ren_d.tag    = tag_cnt;
	end

	stage_reg #(.payload_t(insn_pkg::ren_pkt_t)) u_ren (
		.clk(clk), .rst(rst), .advance(advance_seg2),
		.in_valid(dec_live), .in_data(ren_d), .out_valid(ren_v), .out_data(ren_q)
	);

	assign ren_live = ren_v && !stomp_ren;

	stage_reg #(.payload_t(insn_pkg::ren_pkt_t)) u_que (
		.clk(clk), .rst(rst), .advance(advance_seg2),
		.in_valid(ren_live), .in_data(ren_q), .out_valid(que_v), .out_data(que_q)
	);

	// Renamed words stomped by a miss still queue, but only as copy targets
	assign que_valid  = que_v && !stomp_que && !stomp_quem;
	assign que_copy   = que_v && !stomp_que && stomp_quem;
	assign que_pc     = que_q.pc;
	assign que_opcode = que_q.opcode;
	assign que_tag    = que_q.tag;

	//====================
	// Control
	//====================

	// Decode word is the one at the decoder input, in the mux stage
	fe_predecode u_predecode (
		.clk(clk), .rst(rst), .advance_pipeline(advance_pipeline),
		.fetch_word(fet_q.word), .dec_word(mux_q.word), .dec_valid(mux_live),
		.do_bsr(do_bsr), .micro_code_active(micro_code_active)
	);

	branch_recovery_fsm u_recovery (
		.clk(clk), .rst(rst), .branchmiss(branchmiss),
		.branch_state(branch_state), .recovering(recovering)
	);

	fe_flush_ctrl u_flush (
		.clk(clk), .rst(rst), .ihit(ihit), .hold_front(hold_front),
		.hold_back(hold_back), .micro_code_active(micro_code_active),
		.branchmiss(branchmiss), .branch_state(branch_state), .do_bsr(do_bsr),
		.advance_pipeline(advance_pipeline), .advance_seg2(advance_seg2),
		.stomp_fet(), .stomp_mux(stomp_mux), .stomp_dec(stomp_dec),
		.stomp_ren(stomp_ren), .stomp_que(stomp_que), .stomp_quem(stomp_quem)
	);

endmodule

//--- hw/fe_flush_ctrl.sv
//====================
// Front-end flush control
// Segment advance enables and the stage stomp waterfall
//====================

`timescale 1ns/1ps

module fe_flush_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ihit,
	input  logic                    hold_front,
	input  logic                    hold_back,
	input  logic                    micro_code_active,
	input  logic                    branchmiss,
	input  pipe_pkg::branch_state_t branch_state,
	input  logic                    do_bsr,
	output logic                    advance_pipeline,
	output logic                    advance_seg2,
	output logic                    stomp_fet,
	output logic                    stomp_mux,
	output logic                    stomp_dec,
	output logic                    stomp_ren,
	output logic                    stomp_que,
	output logic                    stomp_quem
);

	logic do_bsr_d;
	logic miss_or_rcv;
	logic next_stomp_mux;
	logic next_stomp_dec;
	logic next_stomp_ren;

	//====================
	// Advance enables
	//====================

	// Segment 2 only waits on the back end
	// Segment 1 also needs segment 2 to move, or it would overrun rename
	assign advance_seg2     = !hold_back;
	assign advance_pipeline = advance_seg2 && !hold_front;

	// BSR seen at fetch, kept for one more segment-1 step
	always_ff @(posedge clk) begin
		if (rst) begin
			do_bsr_d <= 1'b0;
		end else if (advance_pipeline) begin
			do_bsr_d <= do_bsr;
		end
	end

	//====================
	// Stomp waterfall
	//====================

	assign miss_or_rcv = branchmiss || pipe_pkg::in_recovery(branch_state);

	// A miss around a BSR leaves the fetch slot holding junk
	assign stomp_fet = !ihit && (do_bsr || do_bsr_d);

	// Micro-code does not need the cache line, so the fetch stomp is masked
	assign next_stomp_mux = (stomp_fet && !micro_code_active) || do_bsr || miss_or_rcv;
	assign next_stomp_dec = stomp_mux || miss_or_rcv;
	assign next_stomp_ren = stomp_dec || miss_or_rcv;

	// Segment-1 stomps move with their stage contents
	// Reset leaves every stage stomped until real words arrive
	always_ff @(posedge clk) begin
		if (rst) begin
			stomp_mux <= 1'b1;
			stomp_dec <= 1'b1;
		end else if (advance_pipeline) begin
			stomp_mux <= next_stomp_mux;
			stomp_dec <= next_stomp_dec;
		end
	end

	// Rename may step while decode holds, and then it takes a bubble
	// Queue entries cannot be dropped after rename, quem marks them as copies
	always_ff @(posedge clk) begin
		if (rst) begin
			stomp_ren  <= 1'b1;
			stomp_que  <= 1'b1;
			stomp_quem <= 1'b1;
		end else if (advance_seg2) begin
			stomp_ren  <= advance_pipeline ? next_stomp_ren : 1'b1;
			stomp_que  <= stomp_ren;
			stomp_quem <= miss_or_rcv;
		end
	end

	// Segment 1 never steps ahead of segment 2
	a_adv_order: assert property (
		@(posedge clk) disable iff (rst)
		advance_pipeline |-> advance_seg2
	) else $error("segment 1 advanced while segment 2 held");

endmodule

//--- hw/branch_recovery_fsm.sv
//====================
// Branch recovery FSM
// Walks the fixed recovery sequence once per branch miss
//====================

`timescale 1ns/1ps

module branch_recovery_fsm (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    branchmiss,
	output pipe_pkg::branch_state_t branch_state,
	output logic                    recovering
);

	pipe_pkg::branch_state_t state_nxt;

	//====================
	// Next state
	//====================

	// Only BS_IDLE looks at branchmiss
	// A miss that lands mid-sequence is dropped and recovery runs to the end
	always_comb begin
		state_nxt = branch_state;
		case (branch_state)
			pipe_pkg::BS_IDLE: begin
				if (branchmiss) begin
					state_nxt = pipe_pkg::BS_CHKPT_RESTORE;
				end
			end
			// Checkpoint restore takes one cycle in this model
			pipe_pkg::BS_CHKPT_RESTORE: state_nxt = pipe_pkg::BS_STATE3;
			pipe_pkg::BS_STATE3:        state_nxt = pipe_pkg::BS_DONE;
			pipe_pkg::BS_DONE:          state_nxt = pipe_pkg::BS_DONE2;
			pipe_pkg::BS_DONE2:         state_nxt = pipe_pkg::BS_IDLE;
			// Unused encodings fall back to idle
			default:                    state_nxt = pipe_pkg::BS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			branch_state <= pipe_pkg::BS_IDLE;
		end else begin
			branch_state <= state_nxt;
		end
	end

	// Four states are in the recovering range, so the flag lasts four cycles
	assign recovering = pipe_pkg::in_recovery(branch_state);

	//====================
	// Checks
	//====================

	// Nothing but a branch miss may start a recovery
	a_idle_exit: assert property (
		@(posedge clk) disable iff (rst)
		(branch_state == pipe_pkg::BS_IDLE) && !branchmiss
			|=> (branch_state == pipe_pkg::BS_IDLE)
	) else $error("recovery started without a branch miss");

endmodule

//--- hw/fe_predecode.sv
//====================
// Front-end predecode
// Spots BSR at fetch and times the micro-code flag from decode
//====================

`timescale 1ns/1ps

module fe_predecode (
	input  logic            clk,
	input  logic            rst,
	input  logic            advance_pipeline,
	input  insn_pkg::insn_t fetch_word,
	input  insn_pkg::insn_t dec_word,
	input  logic            dec_valid,
	output logic            do_bsr,
	output logic            micro_code_active
);

	logic [pipe_pkg::UCODE_CNT_W-1:0] ucode_cnt;
	logic                             ucode_start;

	//====================
	// Fetch classification
	//====================

	// BSR is unconditional, so the word in fetch is enough to redirect
	// No valid qualifier here, the flush controller pairs it with ihit
	assign do_bsr = (insn_pkg::opcode_of(fetch_word) == insn_pkg::OP_BSR);

	//====================
	// Micro-code timing
	//====================

	// A micro-coded opcode counts only if it actually moves into decode
	// A stomped or held copy must not retrigger the flag
	assign ucode_start = advance_pipeline && dec_valid
		&& (insn_pkg::opcode_of(dec_word) == insn_pkg::OP_UCODE);

	// Down-counter reloads on every new micro-coded opcode
	// Otherwise it runs out to zero and stops there
	always_ff @(posedge clk) begin
		if (rst) begin
			ucode_cnt <= '0;
		end else if (ucode_start) begin
			ucode_cnt <= pipe_pkg::UCODE_LEN[pipe_pkg::UCODE_CNT_W-1:0];
		end else if (ucode_cnt != '0) begin
			ucode_cnt <= ucode_cnt - 1'b1;
		end
	end

	// Flag covers exactly UCODE_LEN cycles after the last start
	assign micro_code_active = (ucode_cnt != '0);

	// Counter stays within the programmed length over its whole life
	a_ucode_cnt_range: assert property (
		@(posedge clk) disable iff (rst)
		ucode_cnt <= pipe_pkg::UCODE_LEN
	) else $error("micro-code counter above UCODE_LEN");

endmodule

//--- hw/stage_reg.sv
//====================
// Pipeline stage register
// Holds one payload and its valid bit, loaded on the stage advance
//====================

`timescale 1ns/1ps

module stage_reg #(
	// Payload carried by this stage
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     advance,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	// Valid bit is control state and clears on reset
	// A stage that does not advance keeps its contents for the next cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (advance) begin
			out_valid <= in_valid;
		end
	end

	//====================
	// Payload
	//====================

	// Payload only means something while out_valid is high
	// It loads whenever the stage advances, bubbles included
	always_ff @(posedge clk) begin
		if (advance) begin
			out_data <= in_data;
		end
	end

endmodule

//--- hw/insn_pkg.sv
//====================
// Instruction definitions
// Word format, opcodes and the payload carried by each stage
//====================

package insn_pkg;

	// Field widths
	localparam int INSN_W = 32;
	localparam int PC_W   = 32;
	localparam int OPC_W  = 6;
	localparam int REG_W  = 5;
	localparam int TAG_W  = 6;

	// Opcode sits in the top bits, destination register right below it
	localparam int OPC_LSB = INSN_W - OPC_W;
	localparam int RD_LSB  = OPC_LSB - REG_W;

	typedef logic [INSN_W-1:0] insn_t;

	// Only BSR and UCODE get special handling in the front end
	// Anything else is treated as an ordinary operation
	typedef enum logic [OPC_W-1:0] {
		OP_NOP   = 6'h00,
		OP_ADD   = 6'h01,
		OP_SUB   = 6'h02,
		OP_LD    = 6'h08,
		OP_ST    = 6'h09,
		OP_BSR   = 6'h30,
		OP_UCODE = 6'h3e
	} opcode_t;

	// Fetch and mux stages carry the raw word
	typedef struct packed {
		logic [PC_W-1:0] pc;
		insn_t           word;
	} fetch_pkt_t;

	// Decode stage carries the decoded fields
	typedef struct packed {
		logic [PC_W-1:0]  pc;
		opcode_t          opcode;
		logic [REG_W-1:0] rd;
	} dec_pkt_t;

	// Rename and queue stages add the physical tag
	typedef struct packed {
		logic [PC_W-1:0]  pc;
		opcode_t          opcode;
		logic [REG_W-1:0] rd;
		logic [TAG_W-1:0] tag;
	} ren_pkt_t;

	function automatic opcode_t opcode_of(input insn_t w);
		return opcode_t'(w[INSN_W-1:OPC_LSB]);
	endfunction

	function automatic logic [REG_W-1:0] rd_of(input insn_t w);
		return w[OPC_LSB-1:RD_LSB];
	endfunction

endpackage

//--- hw/pipe_pkg.sv
//====================
// Pipeline control definitions
// Branch-recovery states and the front-end timing constants
//====================

package pipe_pkg;

	//====================
	// Branch recovery
	//====================

	// Recovery sequence after a branch miss, in stepping order
	// The FSM walks these one per cycle and relies on the encoding order
	typedef enum logic [2:0] {
		BS_IDLE          = 3'd0,
		BS_CHKPT_RESTORE = 3'd1,
		BS_STATE3        = 3'd2,
		BS_DONE          = 3'd3,
		BS_DONE2         = 3'd4
	} branch_state_t;

	// High over the whole recovering range, BS_CHKPT_RESTORE up to BS_DONE2
	function automatic logic in_recovery(input branch_state_t s);
		return (s >= BS_CHKPT_RESTORE) && (s <= BS_DONE2);
	endfunction

	//====================
	// Micro-code timing
	//====================

	// Cycles the micro-code flag stays up once a micro-coded opcode decodes
	localparam int UCODE_LEN = 3;

	// Width of the down-counter that times the micro-code flag
	localparam int UCODE_CNT_W = $clog2(UCODE_LEN + 1);

endpackage
